//--- Bender.yml
package:
  name: store_streamer

sources:
  - stream_pkg.sv
  - stream_fifo.sv
  - strobe_gen.sv
  - addr_gen.sv
  - mem_write_join.sv
  - store_streamer.sv
  - target: test
    files:
      - tb_store_checks.sv
      - tb_store_streamer.sv

//--- addr_gen.sv
/* address generator for store streams
   walks lines and words of the job and emits one word address per handshake */

`default_nettype none

module addr_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,        // aborts the job
  input  logic                    start_i,        // one-cycle pulse while idle
  input  stream_pkg::stream_cfg_t cfg_i,
  output logic                    busy_o,
  output logic                    addr_valid_o,
  output stream_pkg::addr_beat_t  addr_beat_o,
  input  logic                    addr_ready_i
);

  import stream_pkg::*;

  logic                  busy_q;       // job in progress with addresses pending
  logic [cnt_width-1:0]  word_cnt_q;   // word index within the current line
  logic [cnt_width-1:0]  line_cnt_q;   // index of the current line
  logic [addr_width-1:0] line_base_q;  // byte address of the current line start
  logic                  last_word;    // word closes its line
  logic                  last_line;    // current line is the final one
  logic                  handshake;    // address taken this cycle

  assign last_word = (word_cnt_q == cfg_i.line_length - cnt_width'(1));
  assign last_line = (line_cnt_q == cfg_i.line_count - cnt_width'(1));
  assign handshake = addr_valid_o & addr_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      word_cnt_q  <= '0;
      line_cnt_q  <= '0;
      line_base_q <= '0;
    end else if (clear_i) begin
      busy_q      <= 1'b0;  // abort and rewind to line zero
      word_cnt_q  <= '0;
      line_cnt_q  <= '0;
      line_base_q <= '0;
    end else if (start_i && !busy_q) begin
      busy_q      <= 1'b1;             // first address valid from the next cycle
      word_cnt_q  <= '0;
      line_cnt_q  <= '0;
      line_base_q <= cfg_i.base_addr;  // line 0 starts at the base
    end else if (handshake) begin
      if (!last_word) begin
        word_cnt_q <= word_cnt_q + cnt_width'(1);  // next word in the same line
      end else if (!last_line) begin
        word_cnt_q  <= '0;
        line_cnt_q  <= line_cnt_q + cnt_width'(1);
        line_base_q <= line_base_q + addr_width'(cfg_i.line_stride);  // replaces line*stride
      end else begin
        busy_q     <= 1'b0;  // final address of the job has gone
        word_cnt_q <= '0;
        line_cnt_q <= '0;
      end
    end
  end

  assign busy_o       = busy_q;
  assign addr_valid_o = busy_q;  // one address per cycle while the sink is ready

  // the word offset is the word counter shifted by two
  assign addr_beat_o.addr = line_base_q + (addr_width'(word_cnt_q) << 2);
  assign addr_beat_o.last = last_word & last_line;

  // a new job only starts once the previous one has finished
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !busy_q)
    else $error("addr_gen started while busy");

endmodule

`default_nettype wire

//--- build.f
stream_pkg.sv
stream_fifo.sv
strobe_gen.sv
addr_gen.sv
mem_write_join.sv
store_streamer.sv
tb_store_checks.sv
tb_store_streamer.sv

//--- mem_write_join.sv
/* memory write join
   pairs one address with one data beat and issues a write request, popping both on grant */

`default_nettype none

module mem_write_join (
  input  logic                     addr_valid_i,
  input  stream_pkg::addr_beat_t   addr_beat_i,
  output logic                     addr_ready_o,
  input  logic                     data_valid_i,
  input  stream_pkg::stream_beat_t data_beat_i,
  output logic                     data_ready_o,
  output logic                     mem_req_o,
  output stream_pkg::mem_req_t     mem_o,
  input  logic                     mem_gnt_i,
  output logic                     done_o         // pulses on the grant of the last address
);

  logic granted;  // write completes this cycle

  // a request needs both halves, so req never depends on the grant
  assign mem_req_o = addr_valid_i & data_valid_i;
  assign granted   = mem_req_o & mem_gnt_i;

  // payload comes straight from the two FIFO heads, stable while they wait
  assign mem_o.addr  = addr_beat_i.addr;
  assign mem_o.wdata = data_beat_i.data;
  assign mem_o.be    = data_beat_i.strb;

  // both streams advance together and only on a completed write
  assign addr_ready_o = data_valid_i & mem_gnt_i;
  assign data_ready_o = addr_valid_i & mem_gnt_i;

  assign done_o = granted & addr_beat_i.last;  // end of job seen at the memory port

endmodule

`default_nettype wire

//--- store_streamer.sv
/* store streamer top level
   strobe generator and data FIFO on one side, address generator and FIFO on the other */

`default_nettype none

module store_streamer (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,     // flushes FIFOs and counters
  input  logic                     start_i,     // starts a job while idle
  input  stream_pkg::stream_cfg_t  cfg_i,       // held from start until done
  input  logic                     in_valid_i,
  input  stream_pkg::stream_beat_t in_beat_i,
  output logic                     in_ready_o,
  output logic                     mem_req_o,
  output stream_pkg::mem_req_t     mem_o,
  input  logic                     mem_gnt_i,
  output logic                     busy_o,
  output logic                     done_o
);

  import stream_pkg::*;

  logic         sg_valid;     // strobe generator to data FIFO
  stream_beat_t sg_beat;
  logic         sg_ready;
  logic         data_valid;   // data FIFO to join
  stream_beat_t data_beat;
  logic         data_ready;
  logic         ag_valid;     // address generator to address FIFO
  addr_beat_t   ag_beat;
  logic         ag_ready;
  logic         addr_valid;   // address FIFO to join
  addr_beat_t   addr_beat;
  logic         addr_ready;

  strobe_gen i_strobe_gen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .cfg_i        (cfg_i),
    .push_valid_i (in_valid_i),
    .push_beat_i  (in_beat_i),
    .push_ready_o (in_ready_o),
    .pop_valid_o  (sg_valid),
    .pop_beat_o   (sg_beat),
    .pop_ready_i  (sg_ready)
  );

  stream_fifo #(
    .depth     (4),
    .payload_t (stream_beat_t)
  ) i_data_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .push_valid_i (sg_valid),
    .push_data_i  (sg_beat),
    .push_ready_o (sg_ready),
    .pop_valid_o  (data_valid),
    .pop_data_o   (data_beat),
    .pop_ready_i  (data_ready)
  );

  addr_gen i_addr_gen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .start_i      (start_i),
    .cfg_i        (cfg_i),
    .busy_o       (busy_o),
    .addr_valid_o (ag_valid),
    .addr_beat_o  (ag_beat),
    .addr_ready_i (ag_ready)
  );

  stream_fifo #(
    .depth     (2),
    .payload_t (addr_beat_t)
  ) i_addr_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .push_valid_i (ag_valid),
    .push_data_i  (ag_beat),
    .push_ready_o (ag_ready),
    .pop_valid_o  (addr_valid),
    .pop_data_o   (addr_beat),
    .pop_ready_i  (addr_ready)
  );

  mem_write_join i_mem_write_join (
    .addr_valid_i (addr_valid),
    .addr_beat_i  (addr_beat),
    .addr_ready_o (addr_ready),
    .data_valid_i (data_valid),
    .data_beat_i  (data_beat),
    .data_ready_o (data_ready),
    .mem_req_o    (mem_req_o),
    .mem_o        (mem_o),
    .mem_gnt_i    (mem_gnt_i),
    .done_o       (done_o)
  );

  // a pending write holds req and payload until granted, across FIFOs and join
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_o)))
    else $error("memory request changed before grant");

endmodule

`default_nettype wire

//--- stream_fifo.sv
/* stream FIFO with valid/ready on both sides
   circular buffer with registered output whose depth and payload type are set per instance */

`default_nettype none

module stream_fifo #(
  parameter int unsigned depth     = 2,              // number of entries which is at least 2
  parameter type         payload_t = logic [31:0]    // beat type carried through
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,       // drops all entries
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i
);

  typedef logic [$clog2(depth)-1:0]   ptr_t;  // index into the storage array
  typedef logic [$clog2(depth+1)-1:0] cnt_t;  // occupancy from 0 up to depth

  payload_t mem_q [depth];  // storage array of the beats
  ptr_t     wr_ptr_q;       // next slot to write
  ptr_t     rd_ptr_q;       // oldest entry
  cnt_t     count_q;        // entries in use
  logic     push;
  logic     pop;

  assign push_ready_o = (count_q < cnt_t'(depth));  // free slot left
  assign pop_valid_o  = (count_q != '0);            // head holds a beat
  assign pop_data_o   = mem_q[rd_ptr_q];            // straight from the storage register

  assign push = push_valid_i & push_ready_o;  // beat accepted this cycle
  assign pop  = pop_valid_o & pop_ready_i;    // head leaves this cycle

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;  // empty in one edge
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(depth-1)) ? '0 : wr_ptr_q + ptr_t'(1);  // wrap at the end
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(depth-1)) ? '0 : rd_ptr_q + ptr_t'(1);
      end
      if (push && !pop) begin
        count_q <= count_q + cnt_t'(1);
      end else if (pop && !push) begin
        count_q <= count_q - cnt_t'(1);  // push and pop together keep the count
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;  // new beat goes to the write slot
    end
  end

  // a push while full or a pop while empty drives the occupancy out of range
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= cnt_t'(depth))
    else $error("stream_fifo occupancy beyond its depth");
  // the write pointer leads the read pointer by exactly the occupancy
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (int'(wr_ptr_q) == (int'(rd_ptr_q) + int'(count_q)) % depth))
    else $error("stream_fifo pointers disagree with the occupancy");

endmodule

`default_nettype wire

//--- stream_pkg.sv
/* store streamer shared definitions
   configuration layout, stream beats and memory request types */

`default_nettype none

package stream_pkg;

  localparam int unsigned data_width = 32;            // stream data width in bits
  localparam int unsigned strb_width = data_width/8;  // one strobe bit per byte
  localparam int unsigned addr_width = 32;            // byte address width
  localparam int unsigned cnt_width  = 16;            // word and line counter width

  // job description, held stable from start until done
  typedef struct packed {
    logic [addr_width-1:0] base_addr;              // start of line 0, word aligned
    logic [cnt_width-1:0]  line_stride;            // distance between line starts in bytes
    logic [cnt_width-1:0]  line_length;            // words per line incl. partial last word
    logic [cnt_width-1:0]  line_count;             // number of lines in the job
    logic [7:0]            line_length_remainder;  // valid bytes of last word, 0 means all
  } stream_cfg_t;

  // one data word with its byte strobe
  typedef struct packed {
    logic [data_width-1:0] data;  // write data
    logic [strb_width-1:0] strb;  // byte enables
  } stream_beat_t;

  // one word address from the address generator
  typedef struct packed {
    logic [addr_width-1:0] addr;  // byte address of the word
    logic                  last;  // final address of the job
  } addr_beat_t;

  // write request towards the shared memory
  typedef struct packed {
    logic [addr_width-1:0] addr;   // byte address, word aligned
    logic [data_width-1:0] wdata;  // write data
    logic [strb_width-1:0] be;     // byte enables
  } mem_req_t;

endpackage

`default_nettype wire

//--- strobe_gen.sv
/* strobe generator for store streams
   masks the strobe of the final beat of each line by the byte remainder */

`default_nettype none

module strobe_gen (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,       // restarts at the first word of a line
  input  stream_pkg::stream_cfg_t  cfg_i,
  input  logic                     push_valid_i,
  input  stream_pkg::stream_beat_t push_beat_i,
  output logic                     push_ready_o,
  output logic                     pop_valid_o,
  output stream_pkg::stream_beat_t pop_beat_o,
  input  logic                     pop_ready_i
);

  import stream_pkg::*;

  logic [cnt_width-1:0]  beat_cnt_q;  // position of the next beat within its line
  logic                  last_beat;   // current beat closes a line
  logic [strb_width-1:0] rem_mask;    // low bytes kept on the final beat

  assign last_beat = (beat_cnt_q == cfg_i.line_length - cnt_width'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
    end else if (clear_i) begin
      beat_cnt_q <= '0;
    end else if (push_valid_i && push_ready_o) begin
      beat_cnt_q <= last_beat ? '0 : beat_cnt_q + cnt_width'(1);  // wrap after line_length beats
    end
  end

  // thermometer code from the remainder, r gives the r lowest byte enables
  always_comb begin
    rem_mask = '0;
    for (int i = 0; i < strb_width; i++) begin
      rem_mask[i] = (8'(i) < cfg_i.line_length_remainder);
    end
  end

  assign pop_valid_o     = push_valid_i;      // pure pass-through handshake
  assign push_ready_o    = pop_ready_i;
  assign pop_beat_o.data = push_beat_i.data;
  assign pop_beat_o.strb = (last_beat && cfg_i.line_length_remainder != '0) ?
                           (push_beat_i.strb & rem_mask) : push_beat_i.strb;

  // a stalled input beat holds its payload, the counter relies on it
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (push_valid_i && !push_ready_o) |=> (push_valid_i && $stable(push_beat_i)))
    else $error("strobe_gen input changed while stalled");

endmodule

`default_nettype wire

//--- tb_store_checks.sv
/* store streamer checker
   scoreboard of expected writes and concurrent assertions on the memory port */

`default_nettype none

module tb_store_checks (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     start_i,
  input  stream_pkg::stream_cfg_t  cfg_i,
  input  logic                     in_valid_i,
  input  stream_pkg::stream_beat_t in_beat_i,
  input  logic                     in_ready_i,
  input  logic                     mem_req_i,
  input  stream_pkg::mem_req_t     mem_i,
  input  logic                     mem_gnt_i,
  input  logic                     busy_i,
  input  logic                     done_i,
  output logic                     fail_o,     // set by the first failing check
  output logic                     drained_o   // no expected write left over
);

  timeunit 1ns;
  timeprecision 1ps;

  import stream_pkg::*;

  addr_beat_t           addr_q [$];    // expected addresses of the running job in line order
  stream_beat_t         data_q [$];    // accepted input beats with their expected strobe
  logic [cnt_width-1:0] pos_q;         // word position of the next input beat in its line
  mem_req_t             exp_req;       // write the memory port has to show next
  logic                 exp_last;      // that write closes the job
  logic                 exp_valid;     // both halves of the next write are known
  logic                 exp_in_ready;  // data FIFO has a free entry

  initial fail_o = 1'b0;

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
    fail_o = 1'b1;
  endtask

  task automatic report_failure(input string what);
    $display("CHECK FAILED time=%0t %s", $time, what);
    fail_o = 1'b1;
  endtask

  // base + line * stride + word * 4 for every word of the job
  function automatic void queue_job(input stream_cfg_t cfg);
    addr_beat_t beat;
    for (int unsigned l = 0; l < cfg.line_count; l++) begin
      for (int unsigned w = 0; w < cfg.line_length; w++) begin
        beat.addr = cfg.base_addr + l * cfg.line_stride + w * 4;
        beat.last = (l == cfg.line_count - 1) && (w == cfg.line_length - 1);
        addr_q.push_back(beat);
      end
    end
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin
    stream_beat_t beat;
    if (!rst_ni || clear_i) begin
      addr_q.delete();  // a clear drops everything still in flight
      data_q.delete();
      pos_q = '0;
    end else begin
      if (mem_req_i && mem_gnt_i && addr_q.size() > 0 && data_q.size() > 0) begin
        void'(addr_q.pop_front());  // granted write leaves the scoreboard
        void'(data_q.pop_front());
      end
      if (start_i && !busy_i) begin
        queue_job(cfg_i);
      end
      if (in_valid_i && in_ready_i) begin
        beat = in_beat_i;
        if (pos_q == cfg_i.line_length - 1) begin
          if (cfg_i.line_length_remainder != 0) begin
            beat.strb &= strb_width'((32'd1 << cfg_i.line_length_remainder) - 32'd1);
          end
          pos_q = '0;  // next beat opens a new line
        end else begin
          pos_q = pos_q + 1'b1;
        end
        data_q.push_back(beat);
      end
    end
    exp_valid <= (addr_q.size() > 0) && (data_q.size() > 0);
    if (addr_q.size() > 0 && data_q.size() > 0) begin
      exp_req  <= '{addr: addr_q[0].addr, wdata: data_q[0].data, be: data_q[0].strb};
      exp_last <= addr_q[0].last;
    end else begin
      exp_req  <= '0;
      exp_last <= 1'b0;
    end
    exp_in_ready <= (data_q.size() < 4);  // the data FIFO holds four beats
    drained_o    <= (addr_q.size() == 0) && (data_q.size() == 0);
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    mem_req_i |-> (exp_valid && mem_i.addr == exp_req.addr))
    else report_mismatch("mem_o.addr", $sampled(exp_req.addr), $sampled(mem_i.addr));
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    mem_req_i |-> (mem_i.wdata == exp_req.wdata))
    else report_mismatch("mem_o.wdata", $sampled(exp_req.wdata), $sampled(mem_i.wdata));
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    mem_req_i |-> (mem_i.be == exp_req.be))
    else report_mismatch("mem_o.be", $sampled(exp_req.be), $sampled(mem_i.be));
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    done_i == (mem_req_i && mem_gnt_i && exp_last))
    else report_mismatch("done_o", $sampled(mem_req_i && mem_gnt_i && exp_last),
                         $sampled(done_i));
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    in_ready_i == exp_in_ready)
    else report_mismatch("in_ready_o", $sampled(exp_in_ready), $sampled(in_ready_i));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_i && !mem_gnt_i && !clear_i) |=> (mem_req_i && $stable(mem_i)))
    else report_failure("a waiting request changed or dropped before its grant");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (start_i && !busy_i && !clear_i) |=> busy_i)
    else report_failure("busy_o did not rise in the cycle after start_i");
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    done_i |-> !busy_i)
    else report_failure("busy_o still high when the final write was granted");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> (!mem_req_i && !busy_i && !done_i))
    else report_failure("mem_req_o, busy_o or done_o still high after clear_i");
  assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!mem_req_i && !busy_i && !done_i))
    else report_failure("mem_req_o, busy_o or done_o high right after reset");

endmodule

`default_nettype wire

//--- tb_store_streamer.sv
/* store streamer testbench
   runs store jobs with random input gaps and random grants against the checker */

`default_nettype none

module tb_store_streamer;

  timeunit 1ns;
  timeprecision 1ps;

  import stream_pkg::*;

  localparam logic [31:0] lfsr_seed = 32'd75501;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

  logic         clk_i      = 1'b0;
  logic         rst_ni     = 1'b0;
  logic         clear_i    = 1'b0;
  logic         start_i    = 1'b0;
  stream_cfg_t  cfg_i      = '0;
  logic         in_valid_i = 1'b0;
  stream_beat_t in_beat_i  = '0;
  logic         in_ready_o;
  logic         mem_req_o;
  mem_req_t     mem_o;
  logic         mem_gnt_i  = 1'b0;
  logic         busy_o;
  logic         done_o;
  logic         gnt_hold   = 1'b0;       // forces grants low to build back-pressure
  logic [31:0]  gnt_state  = lfsr_seed;  // random source of the memory grants
  logic [31:0]  stim_state = lfsr_seed;  // random source of input gaps and data
  logic         check_failed;
  logic         drained;
  stream_cfg_t  jobs [6];

  always #10 clk_i = ~clk_i;

  store_streamer i_store_streamer (
    .clk_i, .rst_ni, .clear_i, .start_i, .cfg_i, .in_valid_i, .in_beat_i, .in_ready_o,
    .mem_req_o, .mem_o, .mem_gnt_i, .busy_o, .done_o
  );

  tb_store_checks i_checks (
    .clk_i, .rst_ni, .clear_i, .start_i, .cfg_i, .in_valid_i, .in_beat_i,
    .in_ready_i (in_ready_o), .mem_req_i (mem_req_o), .mem_i (mem_o), .mem_gnt_i,
    .busy_i (busy_o), .done_i (done_o), .fail_o (check_failed), .drained_o (drained)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return (state >> 1) ^ (state[0] ? lfsr_taps : 32'h0);
  endfunction

  // one LFSR step per bit, newest bit lands in the lsb
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] bits;
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      stim_state = lfsr_next(stim_state);
      bits       = {bits[30:0], stim_state[0]};
    end
    return bits;
  endfunction

  function automatic stream_cfg_t make_cfg(input logic [31:0] base, input logic [15:0] stride,
                                           input logic [15:0] len, input logic [15:0] count,
                                           input logic [7:0] rem);
    return '{base_addr: base, line_stride: stride, line_length: len, line_count: count,
             line_length_remainder: rem};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic guard_runtime(input realtime limit);
    #(limit);
    abort_run("timeout, the DUT did not finish all jobs in time");
  endtask

  always @(posedge clk_i) begin
    gnt_state = lfsr_next(gnt_state);
    mem_gnt_i <= !gnt_hold && gnt_state[0];  // one random bit per cycle
  end

  initial begin
    wait (check_failed === 1'b1);
    abort_run("a check of the memory port or the status outputs failed");
  end

  // offers beats with random gaps and holds each one until it is taken
  task automatic push_beats(input int unsigned count);
    int unsigned sent;
    logic [31:0] word;
    logic [31:0] strb;
    sent = 0;
    while (sent < count) begin
      @(posedge clk_i);
      if (in_valid_i && in_ready_o) begin
        sent++;
        in_valid_i <= 1'b0;
      end
      if (sent < count && (!in_valid_i || in_ready_o) && take_bits(1) != 0) begin
        word = take_bits(32);
        strb = take_bits(strb_width);
        in_beat_i  <= '{data: word, strb: strb[strb_width-1:0]};
        in_valid_i <= 1'b1;
      end
    end
  endtask

  task automatic run_job(input stream_cfg_t cfg, input int unsigned stall);
    @(posedge clk_i);
    cfg_i    <= cfg;
    start_i  <= 1'b1;
    gnt_hold <= (stall != 0);
    @(posedge clk_i);
    start_i <= 1'b0;
    fork
      push_beats(cfg.line_length * cfg.line_count);
      begin
        repeat (stall) @(posedge clk_i);
        gnt_hold <= 1'b0;  // FIFOs are full by now and in_ready_o is low
      end
    join
    do begin
      @(posedge clk_i);
    end while (!done_o);
  endtask

  // starts a job, leaves writes pending in both FIFOs and clears them
  task automatic abort_job(input stream_cfg_t cfg, input int unsigned beats);
    @(posedge clk_i);
    cfg_i    <= cfg;
    start_i  <= 1'b1;
    gnt_hold <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    push_beats(beats);
    repeat (3) @(posedge clk_i);
    clear_i  <= 1'b1;
    gnt_hold <= 1'b0;
    @(posedge clk_i);
    clear_i <= 1'b0;
  endtask

  initial begin
    int unsigned total;
    jobs[0] = make_cfg(32'h0000_1000, 16'h0040, 5, 3, 0);  // full words with a long grant stall
    jobs[1] = make_cfg(32'h0000_2000, 16'h0020, 4, 2, 1);
    jobs[2] = make_cfg(32'h0000_3004, 16'h0100, 3, 3, 3);
    jobs[3] = make_cfg(32'h0000_4000, 16'h0010, 1, 4, 2);  // every word closes a line
    jobs[4] = make_cfg(32'h0000_5000, 16'h0040, 5, 3, 0);  // cut short by a clear
    jobs[5] = make_cfg(32'h0000_6008, 16'h0030, 3, 2, 3);
    total = 0;
    foreach (jobs[j]) begin
      total += jobs[j].line_length * jobs[j].line_count;
    end
    fork
      guard_runtime(4.0 * total * 20.0 + 3000.0);
    join_none
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    run_job(jobs[0], 20);
    run_job(jobs[1], 0);
    run_job(jobs[2], 0);
    run_job(jobs[3], 0);
    abort_job(jobs[4], 3);
    run_job(jobs[5], 0);  // strobe position must restart at zero
    repeat (4) @(posedge clk_i);
    if (check_failed || !drained) begin
      abort_run("expected writes were left over at the end of the run");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire
